//--- polar_enc_top.f
source/polar_enc_pkg.sv
source/polar_kernel_enc.sv
source/polar_word_stage.sv
source/polar_frame_out.sv
source/polar_enc_top.sv
verif/polar_enc_asserts.sv
verif/polar_enc_tb.sv

//--- verif/polar_enc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module polar_enc_tb;

  localparam int cLOG_WORDS = 3;                      // DUT runs with its default.
  localparam int cWORDS     = 2 ** cLOG_WORDS;
  localparam int cWORD_W    = polar_enc_pkg::cWORD_W;
  localparam int cBITS      = cWORDS * cWORD_W;       // 64 bit frame.
  localparam int cTIMEOUT   = 400;                    // cycles allowed for a drain.

  typedef logic [cBITS-1:0] frame_t;

  logic                      iclk;
  logic                      ireset;
  logic                      iclkena;
  logic                      ival;
  logic                      isof;
  polar_enc_pkg::word_dat_t  idat;
  logic                      ovalid;
  logic                      osof;
  logic                      oeof;
  polar_enc_pkg::word_dat_t  odat;
  polar_enc_pkg::frame_num_t oframe_num;
  logic                      oframe_err;

  integer                    seed = 57765;
  int                        errors;
  int                        words_seen;
  int                        frames_seen;
  frame_t                    exp_q [$];   // expected frames in output order.
  frame_t                    head;        // frame now leaving the DUT.
  logic                      loaded;      // head holds a frame.
  int                        out_idx;     // word of head due next.
  polar_enc_pkg::frame_num_t exp_num;
  logic                      err_mark;    // beat on the inputs is a framing error.
  logic                      err_due;     // oframe_err due in this cycle.
  polar_enc_pkg::word_dat_t  exp_dat;

  polar_enc_top DUT (
    .iclk       ( iclk       ),
    .ireset     ( ireset     ),
    .iclkena    ( iclkena    ),
    .ival       ( ival       ),
    .isof       ( isof       ),
    .idat       ( idat       ),
    .ovalid     ( ovalid     ),
    .osof       ( osof       ),
    .oeof       ( oeof       ),
    .odat       ( odat       ),
    .oframe_num ( oframe_num ),
    .oframe_err ( oframe_err )
  );

  always #4 iclk = ~iclk; // 8 ns period.

  // x_j is the xor of every u_i whose bit set covers j.
  function automatic frame_t polar_ref(input frame_t u);
    frame_t x;
    x = '0;
    for (int j = 0; j < cBITS; j++) begin
      for (int i = 0; i < cBITS; i++) begin
        if ((i & j) == j) x[j] = x[j] ^ u[i];
      end
    end
    return x;
  endfunction

  function automatic frame_t rand_frame();
    frame_t f;
    for (int w = 0; w < cBITS / 32; w++) f[w*32 +: 32] = $random(seed);
    return f;
  endfunction

  assign exp_dat = loaded ? head[out_idx*cWORD_W +: cWORD_W] : 'x; // x when no frame is due.

  // walks the expected frames along with the output beats.
  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      loaded  <= 1'b0;
      out_idx <= 0;
      exp_num <= '0;
    end
    else if (ovalid && iclkena) begin
      words_seen <= words_seen + 1;
      if (out_idx == cWORDS - 1) begin
        out_idx     <= 0;
        exp_num     <= exp_num + 1'b1;        // numbers move on after each frame.
        frames_seen <= frames_seen + 1;
        loaded      <= (exp_q.size() != 0);   // back to back frames.
        if (exp_q.size() != 0) head <= exp_q.pop_front();
      end
      else begin
        out_idx <= out_idx + 1;
      end
    end
    else if (!loaded && exp_q.size() != 0) begin
      head   <= exp_q.pop_front();
      loaded <= 1'b1;
    end
  end

  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      err_due <= 1'b0;
    end
    else if (iclkena) begin
      err_due <= ival & err_mark; // one pulse per bad beat.
    end
  end

  a_reset_idle : assert property (@(posedge iclk)
    $past(ireset) |-> (!ovalid && !osof && !oeof && !oframe_err && oframe_num == '0))
    else begin
      errors++;
      $display("Error at %0t ns: outputs not idle in reset, ovalid=%b osof=%b oeof=%b",
        $time, $sampled(ovalid), $sampled(osof), $sampled(oeof),
        " oframe_err=%b oframe_num=%0d, all expected 0",
        $sampled(oframe_err), $sampled(oframe_num));
    end
  a_dat : assert property (@(posedge iclk) disable iff (ireset) ovalid |-> odat == exp_dat)
    else begin
      errors++;
      $display("Error at %0t ns: odat expected %h, got %h", $time, $sampled(exp_dat),
        $sampled(odat));
    end
  a_sof : assert property (@(posedge iclk) disable iff (ireset) ovalid |-> osof == (out_idx == 0))
    else begin
      errors++;
      $display("Error at %0t ns: osof expected %b, got %b", $time, $sampled(out_idx == 0),
        $sampled(osof));
    end
  a_eof : assert property (@(posedge iclk) disable iff (ireset)
    ovalid |-> oeof == (out_idx == cWORDS - 1))
    else begin
      errors++;
      $display("Error at %0t ns: oeof expected %b, got %b", $time,
        $sampled(out_idx == cWORDS - 1), $sampled(oeof));
    end
  a_num : assert property (@(posedge iclk) disable iff (ireset) ovalid |-> oframe_num == exp_num)
    else begin
      errors++;
      $display("Error at %0t ns: oframe_num expected %0d, got %0d", $time, $sampled(exp_num),
        $sampled(oframe_num));
    end
  a_err : assert property (@(posedge iclk) disable iff (ireset) oframe_err == err_due)
    else begin
      errors++;
      $display("Error at %0t ns: oframe_err expected %b, got %b", $time, $sampled(err_due),
        $sampled(oframe_err));
    end
  a_no_gap : assert property (@(posedge iclk) disable iff (ireset) ovalid && !oeof |=> ovalid)
    else begin
      errors++;
      $display("Gap inside an output frame at %0t ns", $time);
    end

  task automatic put_word(input polar_enc_pkg::word_dat_t w, input logic sof, input logic err);
    @(posedge iclk);
    iclkena  <= 1'b1;
    ival     <= 1'b1;
    isof     <= sof;
    idat     <= w;
    err_mark <= err;
  endtask

  // idle cycles where clock enable drops now and then when asked.
  task automatic idle(input int n, input logic ena_rand);
    repeat (n) begin
      @(posedge iclk);
      ival     <= 1'b0;
      isof     <= 1'b0;
      err_mark <= 1'b0;
      iclkena  <= ena_rand ? ({$random(seed)} % 3 != 0) : 1'b1;
    end
  endtask

  task automatic send_frame(input frame_t u, input logic gapped, input logic first_err);
    exp_q.push_back(polar_ref(u));
    for (int w = 0; w < cWORDS; w++) begin
      if (gapped) idle({$random(seed)} % 4, 1'b1);
      put_word(u[w*cWORD_W +: cWORD_W], w == 0, first_err && w == 0);
    end
  endtask

  // waits until every queued frame has left the DUT.
  task automatic drain(input string what);
    int n;
    n = 0;
    @(negedge iclk);
    while ((exp_q.size() != 0 || loaded) && n < cTIMEOUT) begin
      @(negedge iclk);
      n++;
    end
    if (exp_q.size() != 0 || loaded) begin
      errors++;
      $display("Timeout at %0t ns: %s did not all reach the output", $time, what);
    end
  endtask

  initial begin
    iclk     = 1'b0;
    ireset   = 1'b1;
    iclkena  = 1'b1;
    ival     = 1'b0;
    isof     = 1'b0;
    idat     = '0;
    err_mark = 1'b0;
    repeat (2) @(posedge iclk);
    ireset <= 1'b0;
    idle(3, 1'b0);
    for (int b = 0; b < cBITS; b++) begin   // one generator row each.
      send_frame(frame_t'(1) << b, 1'b0, 1'b0);
      idle(2, 1'b0);
    end
    drain("unit vector frames");
    for (int f = 0; f < 20; f++) send_frame(rand_frame(), 1'b0, 1'b0); // full rate.
    idle(1, 1'b0);
    drain("full rate frames");
    for (int f = 0; f < 12; f++) send_frame(rand_frame(), 1'b1, 1'b0);
    idle(1, 1'b0);
    drain("gapped frames");
    for (int w = 0; w < 3; w++) begin       // partial frame that never reaches the output.
      put_word(polar_enc_pkg::word_dat_t'($random(seed)), w == 0, 1'b0);
    end
    send_frame(rand_frame(), 1'b0, 1'b1);   // its sof cuts the partial frame.
    idle(2, 1'b0);
    put_word(polar_enc_pkg::word_dat_t'($random(seed)), 1'b0, 1'b1); // stray word.
    idle(2, 1'b0);
    send_frame(rand_frame(), 1'b0, 1'b0);
    idle(1, 1'b0);
    drain("frames after framing errors");
    idle(4, 1'b0);
    $display("Summary: %0d frames, %0d words, %0d testbench errors, %0d protocol errors",
      frames_seen, words_seen, errors, DUT.u_asserts.fails);
    if (errors == 0 && DUT.u_asserts.fails == 0) begin
      $display("All checks passed");
    end
    else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/polar_enc_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module polar_enc_asserts #(
  parameter int pLOG_WORDS = 3
) (
  iclk       ,
  ireset     ,
  iclkena    ,
  ovalid     ,
  osof       ,
  oeof       ,
  odat       ,
  oframe_num
);

  input logic                      iclk       ;
  input logic                      ireset     ;
  input logic                      iclkena    ;
  input logic                      ovalid     ;
  input logic                      osof       ;
  input logic                      oeof       ;
  input polar_enc_pkg::word_dat_t  odat       ;
  input polar_enc_pkg::frame_num_t oframe_num ;

  localparam polar_enc_pkg::word_addr_t cLAST = polar_enc_pkg::word_addr_t'(2 ** pLOG_WORDS - 1);

  polar_enc_pkg::word_addr_t vcnt;  // valid words taken since osof.
  polar_enc_pkg::word_addr_t vpos;  // index of the word on the ports.
  int                        fails; // failed checks.

  assign vpos = osof ? '0 : vcnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      vcnt <= '0;
    end
    else if (iclkena & ovalid) begin
      vcnt <= vpos + 1'b1; // held words are not counted twice.
    end
  end

  a_marks_valid : assert property (@(posedge iclk) disable iff (ireset) (osof || oeof) |-> ovalid)
    else begin
      fails++;
      $error("osof or oeof without ovalid");
    end

  // eof on word W-1, the Wth valid counting the osof word.
  a_eof_place : assert property (@(posedge iclk) disable iff (ireset)
    ovalid |-> (oeof == (vpos == cLAST)))
    else begin
      fails++;
      $error("oeof not on the last valid word of the frame");
    end

  a_valid_known : assert property (@(posedge iclk) disable iff (ireset) !$isunknown(ovalid))
    else begin
      fails++;
      $error("ovalid is unknown");
    end

  a_data_known : assert property (@(posedge iclk) disable iff (ireset)
    ovalid |-> !$isunknown({osof, oeof, odat, oframe_num}))
    else begin
      fails++;
      $error("unknown value on a valid output word");
    end

endmodule

bind polar_enc_top polar_enc_asserts #(
  .pLOG_WORDS ( pLOG_WORDS )
) u_asserts (
  .iclk       ( iclk       ),
  .ireset     ( ireset     ),
  .iclkena    ( iclkena    ),
  .ovalid     ( ovalid     ),
  .osof       ( osof       ),
  .oeof       ( oeof       ),
  .odat       ( odat       ),
  .oframe_num ( oframe_num )
);

`default_nettype wire

//--- source/polar_enc_top.sv
`timescale 1ns/100ps
`default_nettype none

module polar_enc_top #(
  parameter int pLOG_WORDS = 3
) (
  iclk       ,
  ireset     ,
  iclkena    ,
  ival       ,
  isof       ,
  idat       ,
  ovalid     ,
  osof       ,
  oeof       ,
  odat       ,
  oframe_num ,
  oframe_err
);

  input  logic                      iclk       ;
  input  logic                      ireset     ;
  input  logic                      iclkena    ;
  input  logic                      ival       ;
  input  logic                      isof       ;
  input  polar_enc_pkg::word_dat_t  idat       ;
  output logic                      ovalid     ;
  output logic                      osof       ;
  output logic                      oeof       ;
  output polar_enc_pkg::word_dat_t  odat       ;
  output polar_enc_pkg::frame_num_t oframe_num ;
  output logic                      oframe_err ;

  // link g feeds stage g, the last link feeds the drainer.
  polar_enc_pkg::word_beat_t beat [pLOG_WORDS+1];

  // in-word kernel and framing.
  polar_kernel_enc #(
    .pLOG_WORDS ( pLOG_WORDS )
  ) u_kernel (
    .iclk       ( iclk       ),
    .ireset     ( ireset     ),
    .iclkena    ( iclkena    ),
    .ival       ( ival       ),
    .isof       ( isof       ),
    .idat       ( idat       ),
    .beat_out   ( beat[0]    ),
    .oframe_err ( oframe_err )
  );

  // word butterflies at distance 1, 2, 4 ...
  for (genvar g = 0; g < pLOG_WORDS; g++) begin : g_stage
    polar_word_stage #(
      .pLOG_WORDS ( pLOG_WORDS ),
      .pSTAGE     ( g          )
    ) u_stage (
      .iclk     ( iclk      ),
      .ireset   ( ireset    ),
      .iclkena  ( iclkena   ),
      .beat_in  ( beat[g]   ),
      .beat_out ( beat[g+1] )
    );
  end

  polar_frame_out #(
    .pLOG_WORDS ( pLOG_WORDS )
  ) u_frame_out (
    .iclk       ( iclk             ),
    .ireset     ( ireset           ),
    .iclkena    ( iclkena          ),
    .beat_in    ( beat[pLOG_WORDS] ),
    .ovalid     ( ovalid           ),
    .osof       ( osof             ),
    .oeof       ( oeof             ),
    .odat       ( odat             ),
    .oframe_num ( oframe_num       )
  );

endmodule

`default_nettype wire

//--- source/polar_frame_out.sv
`timescale 1ns/100ps
`default_nettype none

module polar_frame_out #(
  parameter int pLOG_WORDS = 3
) (
  iclk       ,
  ireset     ,
  iclkena    ,
  beat_in    ,
  ovalid     ,
  osof       ,
  oeof       ,
  odat       ,
  oframe_num
);

  input  logic                      iclk       ;
  input  logic                      ireset     ;
  input  logic                      iclkena    ;
  input  polar_enc_pkg::word_beat_t beat_in    ;
  output logic                      ovalid     ;
  output logic                      osof       ;
  output logic                      oeof       ;
  output polar_enc_pkg::word_dat_t  odat       ;
  output polar_enc_pkg::frame_num_t oframe_num ;

  localparam int cWORDS = 2 ** pLOG_WORDS;
  localparam polar_enc_pkg::word_addr_t cLAST = polar_enc_pkg::word_addr_t'(cWORDS - 1);

  polar_enc_pkg::word_addr_t cnt; // words seen since sof.
  polar_enc_pkg::word_addr_t pos; // index of the incoming word.

  assign pos = beat_in.sof ? '0 : cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ovalid     <= 1'b0;
      osof       <= 1'b0;
      oeof       <= 1'b0;
      cnt        <= '0;
      oframe_num <= '0;
    end
    else if (iclkena) begin
      ovalid <= beat_in.val;
      osof   <= beat_in.val & beat_in.sof;
      oeof   <= beat_in.val & (pos == cLAST); // last word of the frame.
      if (beat_in.val) begin
        cnt <= (pos == cLAST) ? '0 : pos + 1'b1;
      end
      // number moves on once the eof word has gone out.
      if (oeof) begin
        oframe_num <= oframe_num + 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena & beat_in.val) begin
      odat <= beat_in.dat;
    end
  end

endmodule

`default_nettype wire

//--- source/polar_word_stage.sv
`timescale 1ns/100ps
`default_nettype none

module polar_word_stage #(
  parameter int pLOG_WORDS = 3,
  parameter int pSTAGE     = 0
) (
  iclk     ,
  ireset   ,
  iclkena  ,
  beat_in  ,
  beat_out
);

  input  logic                      iclk     ;
  input  logic                      ireset   ;
  input  logic                      iclkena  ;
  input  polar_enc_pkg::word_beat_t beat_in  ;
  output polar_enc_pkg::word_beat_t beat_out ;

  localparam int cWORDS = 2 ** pLOG_WORDS;
  localparam polar_enc_pkg::word_addr_t cLAST = polar_enc_pkg::word_addr_t'(cWORDS - 1);
  localparam polar_enc_pkg::word_addr_t cDIST = polar_enc_pkg::word_addr_t'(1 << pSTAGE);

  // ping-pong frame buffer.
  polar_enc_pkg::word_dat_t  mem [2][cWORDS];

  // write side.
  polar_enc_pkg::word_addr_t wr_idx;   // next write index.
  polar_enc_pkg::word_addr_t wr_ptr;   // index used in this cycle.
  logic                      wr_bank;  // bank being filled.
  logic                      wr_last;  // last word of a frame written.

  // read side.
  logic                      rd_act;   // bank readout in progress.
  polar_enc_pkg::word_addr_t rd_cnt;   // word j being produced.
  logic                      rd_bank;  // bank being drained.
  logic                      rd_last;
  logic [pLOG_WORDS-1:0]     lo_addr;  // word j.
  logic [pLOG_WORDS-1:0]     hi_addr;  // word j with bit s set.
  polar_enc_pkg::word_dat_t  lo_dat;
  polar_enc_pkg::word_dat_t  hi_dat;

  logic                      out_val;
  logic                      out_sof;
  polar_enc_pkg::word_dat_t  out_dat;

  assign wr_ptr  = beat_in.sof ? '0 : wr_idx; // sof mid-frame drops the partial frame.
  assign wr_last = beat_in.val & (wr_ptr == cLAST);

  always_ff @(posedge iclk) begin
    if (iclkena & beat_in.val) begin
      mem[wr_bank][wr_ptr[pLOG_WORDS-1:0]] <= beat_in.dat;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_idx  <= '0;
      wr_bank <= 1'b0;
    end
    else if (iclkena) begin
      if (beat_in.val) begin
        if (wr_last) begin
          wr_idx  <= '0;
          wr_bank <= ~wr_bank; // full frame, swap banks.
        end
        else begin
          wr_idx  <= wr_ptr + 1'b1;
        end
      end
    end
  end

  // two read ports on the drained bank.
  assign lo_addr = rd_cnt[pLOG_WORDS-1:0];
  assign hi_addr = lo_addr | cDIST[pLOG_WORDS-1:0]; // equals lo_addr when bit s is set.
  assign lo_dat  = mem[rd_bank][lo_addr];
  assign hi_dat  = mem[rd_bank][hi_addr];
  assign rd_last = rd_act & (rd_cnt == cLAST);

  // readout starts the cycle after the last write.
  // a new frame may end just as the old one is drained.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_act  <= 1'b0;
      rd_cnt  <= '0;
      rd_bank <= 1'b0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
    end
    else if (iclkena) begin
      if (wr_last) begin
        rd_act  <= 1'b1;
        rd_cnt  <= '0;
        rd_bank <= wr_bank; // drain the bank just filled.
      end
      else if (rd_last) begin
        rd_act  <= 1'b0;
      end
      else if (rd_act) begin
        rd_cnt  <= rd_cnt + 1'b1;
      end
      out_val <= rd_act;
      out_sof <= rd_act & (rd_cnt == '0);
    end
  end

  // butterfly, low word of the pair takes the xor.
  always_ff @(posedge iclk) begin
    if (iclkena & rd_act) begin
      out_dat <= lo_addr[pSTAGE] ? lo_dat : (lo_dat ^ hi_dat);
    end
  end

  assign beat_out = '{val: out_val, sof: out_sof, dat: out_dat};

endmodule

`default_nettype wire

//--- source/polar_kernel_enc.sv
`timescale 1ns/100ps
`default_nettype none

module polar_kernel_enc #(
  parameter int pLOG_WORDS = 3
) (
  iclk       ,
  ireset     ,
  iclkena    ,
  ival       ,
  isof       ,
  idat       ,
  beat_out   ,
  oframe_err
);

  input  logic                      iclk       ;
  input  logic                      ireset     ;
  input  logic                      iclkena    ;
  input  logic                      ival       ;
  input  logic                      isof       ;
  input  polar_enc_pkg::word_dat_t  idat       ;
  output polar_enc_pkg::word_beat_t beat_out   ;
  output logic                      oframe_err ;

  localparam int cWORDS = 2 ** pLOG_WORDS;
  localparam polar_enc_pkg::word_addr_t cLAST = polar_enc_pkg::word_addr_t'(cWORDS - 1);

  polar_enc_pkg::word_addr_t cnt;     // index of the next expected word.
  polar_enc_pkg::word_addr_t pos;     // index of the word in this cycle.
  logic                      out_val;
  logic                      out_sof;
  polar_enc_pkg::word_dat_t  out_dat;

  // in-word polar transform u*F^(x3) in three butterfly levels.
  // low bit of each pair takes the xor and the high bit passes.
  function automatic polar_enc_pkg::word_dat_t kernel_enc(input polar_enc_pkg::word_dat_t u);
    polar_enc_pkg::word_dat_t x;
    x = u;
    for (int d = 1; d < polar_enc_pkg::cWORD_W; d = d * 2) begin
      for (int k = 0; k < polar_enc_pkg::cWORD_W; k++) begin
        if ((k & d) == 0) begin
          x[k] = x[k] ^ x[k + d]; // pair distance d inside the word.
        end
      end
    end
    return x;
  endfunction

  assign pos = isof ? '0 : cnt; // sof always realigns to word 0.

  // framing control.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt        <= '0;
      out_val    <= 1'b0;
      out_sof    <= 1'b0;
      oframe_err <= 1'b0;
    end
    else if (iclkena) begin
      out_val    <= 1'b0;
      out_sof    <= 1'b0;
      oframe_err <= 1'b0;
      if (ival) begin
        if (!isof && cnt == '0) begin
          oframe_err <= 1'b1;                  // stray word is dropped.
        end
        else begin
          out_val    <= 1'b1;
          out_sof    <= isof;
          oframe_err <= isof & (cnt != '0);    // frame cut short.
          cnt        <= (pos == cLAST) ? '0 : pos + 1'b1;
        end
      end
    end
  end

  // encoded payload word.
  always_ff @(posedge iclk) begin
    if (iclkena & ival) begin
      out_dat <= kernel_enc(idat);
    end
  end

  assign beat_out = '{val: out_val, sof: out_sof, dat: out_dat};

endmodule

`default_nettype wire

//--- source/polar_enc_pkg.sv
`default_nettype none

package polar_enc_pkg;

  // word geometry of the frame.
  localparam int cWORD_W = 8; // bits per frame word, one 8x8 kernel each.

  // largest frame is 2^5 words.
  localparam int cLOG_WORDS_MAX = 5;

  // width of the frame sequence counter.
  localparam int cFRAME_NUM_W = 16;

  // one frame word, bit k of word i is frame bit 8i+k.
  typedef logic [cWORD_W-1:0] word_dat_t;

  // word index inside a frame, sized for the largest frame.
  typedef logic [cLOG_WORDS_MAX-1:0] word_addr_t;

  // frame sequence number at the output.
  typedef logic [cFRAME_NUM_W-1:0] frame_num_t;

  // one word on an internal link.
  // strobe only, there is no back-pressure.
  typedef struct packed {
    logic      val; // word strobe.
    logic      sof; // word 0 of a frame.
    word_dat_t dat; // payload.
  } word_beat_t;

endpackage

`default_nettype wire
